//--- design/aes_ctrl_pkg.sv
////////////////////
// Shared types for the AES cipher control unit
// Key length is one-hot, so values outside the enum decode as AES-128
////////////////////
`default_nettype none

package aes_ctrl_pkg;

  // Round counter width, covers up to 14 rounds
  parameter int RndCtrWidth = 4;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // One-hot key length
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic [2:0] {
    CIPHER_CTRL_IDLE,
    CIPHER_CTRL_INIT,
    CIPHER_CTRL_ROUND,
    CIPHER_CTRL_FINISH,
    CIPHER_CTRL_CLEAR_S,
    CIPHER_CTRL_CLEAR_KD,
    CIPHER_CTRL_ERROR
  } cipher_state_e;

  // Phase as seen by the key selector decoder
  typedef enum logic [1:0] {PHASE_INIT, PHASE_ROUND, PHASE_FINISH, PHASE_OTHER} round_phase_e;

  typedef enum logic [1:0] {STATE_ROUND, STATE_INIT, STATE_CLEAR} state_sel_e;
  typedef enum logic [1:0] {ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL} add_rk_sel_e;

  typedef enum logic [1:0] {
    KEY_FULL_ENC_INIT,
    KEY_FULL_DEC_INIT,
    KEY_FULL_ROUND,
    KEY_FULL_CLEAR
  } key_full_sel_e;

  typedef enum logic {KEY_DEC_EXPAND, KEY_DEC_CLEAR} key_dec_sel_e;

  typedef enum logic [1:0] {
    KEY_WORDS_0123,
    KEY_WORDS_2345,
    KEY_WORDS_4567,
    KEY_WORDS_ZERO
  } key_words_sel_e;

  typedef enum logic {ROUND_KEY_DIRECT, ROUND_KEY_MIXED} round_key_sel_e;

  // Total number of rounds for a key length
  function automatic logic [RndCtrWidth-1:0] num_rounds(key_len_e key_len);
    case (key_len)
      AES_192: return RndCtrWidth'(12);
      AES_256: return RndCtrWidth'(14);
      default: return RndCtrWidth'(10);
    endcase
  endfunction

endpackage

`default_nettype wire

//--- design/aes_ctrl_if.sv
////////////////////
// Internal links between the control FSM, the round timer and the key decoder
// All signals are single-cycle combinational values, sampled by the receiver
////////////////////
`timescale 1ns/1ps
`default_nettype none

// Round bookkeeping between FSM and timer
interface round_if import aes_ctrl_pkg::*; ();
  // Load round total and clear round counter
  logic                   start;
  // Next round, clears the cycle counter
  logic                   step;
  // Hold cycle counter at zero
  logic                   cyc_clear;
  key_len_e               key_len;
  logic [RndCtrWidth-1:0] rnd_ctr;
  // Counter has reached the last regular round
  logic                   last_regular;
  // Minimum cycles per round have passed
  logic                   cyc_done;

  modport fsm   (output start, step, cyc_clear, key_len,
                 input  rnd_ctr, last_regular, cyc_done);
  modport timer (input  start, step, cyc_clear, key_len,
                 output rnd_ctr, last_regular, cyc_done);
endinterface

// Selector decode between FSM and key decoder
interface key_sel_if import aes_ctrl_pkg::*; ();
  round_phase_e   phase;
  ciph_op_e       op;
  key_len_e       key_len;
  logic           dec_key_gen;
  // Full key register load at command start
  logic           load;
  // Full key register wipe
  logic           clear;
  key_words_sel_e key_words_sel;
  round_key_sel_e round_key_sel;
  key_full_sel_e  key_full_sel;

  modport fsm (output phase, op, key_len, dec_key_gen, load, clear,
               input  key_words_sel, round_key_sel, key_full_sel);
  modport dec (input  phase, op, key_len, dec_key_gen, load, clear,
               output key_words_sel, round_key_sel, key_full_sel);
endinterface

`default_nettype wire

//--- design/aes_round_timer.sv
////////////////////
// Round counter and minimum-cycles-per-round timer
// SBoxLatency must lie in 1..8, the cycle counter is 3 bits wide
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_round_timer import aes_ctrl_pkg::*; #(
  parameter int SBoxLatency = 5
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  round_if.timer   rnd
);

  localparam int              CycWidth = 3;
  localparam logic [CycWidth-1:0] CycMax = CycWidth'(SBoxLatency - 1);

  logic [RndCtrWidth-1:0] rnd_ctr_q;
  logic [RndCtrWidth-1:0] num_rounds_q;
  logic [CycWidth-1:0]    cyc_ctr_q;

  // Round total latched on start, counter runs on step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= '0;
    end else if (rnd.start) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= num_rounds(rnd.key_len);
    end else if (rnd.step) begin
      rnd_ctr_q    <= rnd_ctr_q + RndCtrWidth'(1);
    end
  end

  // Cycles since the last step, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_ctr_q <= '0;
    end else if (rnd.cyc_clear || rnd.start || rnd.step) begin
      cyc_ctr_q <= '0;
    end else if (cyc_ctr_q < CycMax) begin
      cyc_ctr_q <= cyc_ctr_q + CycWidth'(1);
    end
  end

  assign rnd.rnd_ctr      = rnd_ctr_q;
  assign rnd.last_regular = rnd_ctr_q >= (num_rounds_q - RndCtrWidth'(1));
  assign rnd.cyc_done     = cyc_ctr_q >= CycMax;

  ////////////////////
  // Assertions
  ////////////////////

  // FSM never cuts a round short
  // AES-256 initial round is exempt, both first round keys are present at once
  a_step_after_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rnd.step && !(rnd_ctr_q == '0 && rnd.key_len == AES_256) |-> rnd.cyc_done)
    else $error("round step before minimum S-Box latency");

endmodule

`default_nettype wire

//--- design/aes_key_sel.sv
////////////////////
// Key selector decoder, purely combinational
// Key words follow the round phase, ZERO outside INIT/ROUND/FINISH
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_key_sel import aes_ctrl_pkg::*; (
  key_sel_if.dec sel
);

  logic fwd;
  logic init_phase;

  assign fwd        = sel.op == CIPH_FWD;
  assign init_phase = sel.phase == PHASE_INIT;

  // Key words for add-round-key
  always_comb begin
    if (sel.dec_key_gen || sel.phase == PHASE_OTHER) begin
      sel.key_words_sel = KEY_WORDS_ZERO;
    end else begin
      unique case (sel.key_len)
        AES_128: sel.key_words_sel = KEY_WORDS_0123;
        // Forward starts low and moves up, inverse the other way round
        AES_192: sel.key_words_sel = (init_phase == fwd) ? KEY_WORDS_0123 : KEY_WORDS_2345;
        AES_256: sel.key_words_sel = (init_phase == fwd) ? KEY_WORDS_0123 : KEY_WORDS_4567;
        default: sel.key_words_sel = KEY_WORDS_ZERO;
      endcase
    end
  end

  // Equivalent inverse cipher mixes the round key in regular rounds only
  assign sel.round_key_sel = (!fwd && sel.phase == PHASE_ROUND) ? ROUND_KEY_MIXED
                                                                : ROUND_KEY_DIRECT;

  // Full key register source
  always_comb begin
    if (sel.clear) begin
      sel.key_full_sel = KEY_FULL_CLEAR;
    end else if (sel.load) begin
      // Decryption key only for an inverse crypt, key generation starts from encryption key
      sel.key_full_sel = (!fwd && !sel.dec_key_gen) ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;
    end else begin
      sel.key_full_sel = KEY_FULL_ROUND;
    end
  end

endmodule

`default_nettype wire

//--- design/aes_cipher_fsm.sv
////////////////////
// AES cipher control FSM
// One command per input handshake, clear has priority over crypt
// ERROR is terminal, only reset leaves it
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_cipher_fsm import aes_ctrl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Command handshake
  input  logic          in_valid_i,
  output logic          in_ready_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  // Command and config
  input  ciph_op_e      op_i,
  input  key_len_e      key_len_i,
  input  logic          crypt_i,
  input  logic          dec_key_gen_i,
  input  logic          key_clear_i,
  input  logic          data_out_clear_i,
  // Data path
  output state_sel_e    state_sel_o,
  output logic          state_we_o,
  output logic          sub_bytes_en_o,
  input  logic          sub_bytes_out_req_i,
  output logic          sub_bytes_out_ack_o,
  output add_rk_sel_e   add_rk_sel_o,
  // Key path
  output logic          key_full_we_o,
  output key_dec_sel_e  key_dec_sel_o,
  output logic          key_dec_we_o,
  output logic          key_expand_en_o,
  input  logic          key_expand_out_req_i,
  output logic          key_expand_out_ack_o,
  output logic          key_expand_clear_o,
  // Fault and alert
  input  logic          fatal_i,
  output logic          alert_o,
  round_if.fsm          rnd,
  key_sel_if.fsm        sel
);

  cipher_state_e state_d, state_q;
  logic crypt_d, crypt_q;
  logic dec_key_gen_d, dec_key_gen_q;
  logic key_clear_d, key_clear_q;
  logic data_out_clear_d, data_out_clear_q;
  logic do_crypt;
  logic advance;

  // Key generation wins when both crypt and key generation are requested
  assign do_crypt = crypt_q & ~dec_key_gen_q;

  assign rnd.key_len     = key_len_i;
  assign sel.key_len     = key_len_i;
  assign sel.op          = op_i;
  // In IDLE the decoder must see the incoming command for the key load
  assign sel.dec_key_gen = (state_q == CIPHER_CTRL_IDLE) ? dec_key_gen_i : dec_key_gen_q;

  always_comb begin
    in_ready_o           = 1'b0;
    out_valid_o          = 1'b0;
    state_sel_o          = STATE_ROUND;
    state_we_o           = 1'b0;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;
    add_rk_sel_o         = ADD_RK_ROUND;
    key_full_we_o        = 1'b0;
    key_dec_sel_o        = KEY_DEC_EXPAND;
    key_dec_we_o         = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;
    alert_o              = 1'b0;
    rnd.start            = 1'b0;
    rnd.step             = 1'b0;
    rnd.cyc_clear        = 1'b0;
    sel.phase            = PHASE_OTHER;
    sel.load             = 1'b0;
    sel.clear            = 1'b0;
    advance              = 1'b0;
    state_d              = state_q;
    crypt_d              = crypt_q;
    dec_key_gen_d        = dec_key_gen_q;
    key_clear_d          = key_clear_q;
    data_out_clear_d     = data_out_clear_q;

    unique case (state_q)
      CIPHER_CTRL_IDLE: begin
        in_ready_o    = 1'b1;
        rnd.cyc_clear = 1'b1;
        if (in_valid_i) begin
          if (key_clear_i || data_out_clear_i) begin
            key_clear_d      = key_clear_i;
            data_out_clear_d = data_out_clear_i;
            // Data output clear goes through a cleared state first
            state_d = data_out_clear_i ? CIPHER_CTRL_CLEAR_S : CIPHER_CTRL_CLEAR_KD;
          end else if (crypt_i || dec_key_gen_i) begin
            crypt_d            = crypt_i;
            dec_key_gen_d      = dec_key_gen_i;
            // Load input block, or clear it for key generation
            state_sel_o        = dec_key_gen_i ? STATE_CLEAR : STATE_INIT;
            state_we_o         = 1'b1;
            key_expand_clear_o = 1'b1;
            sel.load           = 1'b1;
            key_full_we_o      = 1'b1;
            rnd.start          = 1'b1;
            state_d            = CIPHER_CTRL_INIT;
          end else begin
            // Handshake without command
            state_d = CIPHER_CTRL_ERROR;
          end
        end
      end

      CIPHER_CTRL_INIT: begin
        sel.phase    = PHASE_INIT;
        add_rk_sel_o = ADD_RK_INIT;
        if (key_len_i != AES_256) begin
          // Wait for the first KeyExpand result
          key_expand_en_o = 1'b1;
          advance         = key_expand_out_req_i & rnd.cyc_done;
          key_full_we_o   = advance;
          key_expand_out_ack_o = advance;
        end else begin
          // Both first round keys already in the full key
          advance = 1'b1;
        end
        if (advance) begin
          state_we_o = do_crypt;
          rnd.step   = 1'b1;
          state_d    = CIPHER_CTRL_ROUND;
        end
      end

      CIPHER_CTRL_ROUND: begin
        sel.phase       = PHASE_ROUND;
        sub_bytes_en_o  = do_crypt;
        key_expand_en_o = 1'b1;
        advance = key_expand_out_req_i & rnd.cyc_done & (~do_crypt | sub_bytes_out_req_i);
        if (advance) begin
          sub_bytes_out_ack_o  = do_crypt;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = do_crypt;
          key_full_we_o        = 1'b1;
          rnd.step             = 1'b1;
          if (rnd.last_regular) begin
            state_d = CIPHER_CTRL_FINISH;
            if (dec_key_gen_q) begin
              // Decryption key ready, finish here if the handshake is taken
              key_dec_we_o = 1'b1;
              out_valid_o  = 1'b1;
              if (out_ready_i) begin
                crypt_d       = 1'b0;
                dec_key_gen_d = 1'b0;
                state_d       = CIPHER_CTRL_IDLE;
              end
            end
          end
        end
      end

      CIPHER_CTRL_FINISH: begin
        sel.phase      = PHASE_FINISH;
        add_rk_sel_o   = ADD_RK_FINAL;
        // State is wiped on exit
        state_sel_o    = STATE_CLEAR;
        sub_bytes_en_o = do_crypt;
        advance        = dec_key_gen_q | (sub_bytes_out_req_i & rnd.cyc_done);
        out_valid_o    = advance;
        if (advance && out_ready_i) begin
          sub_bytes_out_ack_o = do_crypt;
          state_we_o          = 1'b1;
          crypt_d             = 1'b0;
          dec_key_gen_d       = 1'b0;
          state_d             = CIPHER_CTRL_IDLE;
        end
      end

      CIPHER_CTRL_CLEAR_S: begin
        rnd.cyc_clear = 1'b1;
        state_sel_o   = STATE_CLEAR;
        state_we_o    = 1'b1;
        state_d       = CIPHER_CTRL_CLEAR_KD;
      end

      CIPHER_CTRL_CLEAR_KD: begin
        rnd.cyc_clear = 1'b1;
        if (key_clear_q) begin
          sel.clear     = 1'b1;
          key_full_we_o = 1'b1;
          key_dec_sel_o = KEY_DEC_CLEAR;
          key_dec_we_o  = 1'b1;
        end
        // Pass the cleared state through to the data output
        if (data_out_clear_q) begin
          add_rk_sel_o = ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          key_clear_d      = 1'b0;
          data_out_clear_d = 1'b0;
          state_d          = CIPHER_CTRL_IDLE;
        end
      end

      CIPHER_CTRL_ERROR: begin
        rnd.cyc_clear = 1'b1;
        alert_o       = 1'b1;
      end

      default: begin
        state_d = CIPHER_CTRL_ERROR;
      end
    endcase

    // Any fault wins over the regular flow
    if (fatal_i) begin
      state_d = CIPHER_CTRL_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= CIPHER_CTRL_IDLE;
      crypt_q          <= 1'b0;
      dec_key_gen_q    <= 1'b0;
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else begin
      state_q          <= state_d;
      crypt_q          <= crypt_d;
      dec_key_gen_q    <= dec_key_gen_d;
      key_clear_q      <= key_clear_d;
      data_out_clear_q <= data_out_clear_d;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Result is held until taken, unless a fault intervenes
  a_out_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i && !fatal_i |=> out_valid_o)
    else $error("out_valid_o dropped before handshake");

  // A fault always ends in the alert state, which is never left
  a_fatal_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fatal_i |=> alert_o && state_q == CIPHER_CTRL_ERROR)
    else $error("fatal_i did not raise alert_o");

  a_alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
      alert_o |=> alert_o)
    else $error("alert_o left without reset");

endmodule

`default_nettype wire

//--- design/aes_cipher_control.sv
////////////////////
// AES cipher control unit top level
// SubBytes and KeyExpand hold req until ack
// SBoxLatency sets the minimum cycles per round, 1..8
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_cipher_control import aes_ctrl_pkg::*; #(
  parameter int SBoxLatency = 5
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  input  ciph_op_e               op_i,
  input  key_len_e               key_len_i,
  input  logic                   crypt_i,
  input  logic                   dec_key_gen_i,
  input  logic                   key_clear_i,
  input  logic                   data_out_clear_i,
  output state_sel_e             state_sel_o,
  output logic                   state_we_o,
  output logic                   sub_bytes_en_o,
  input  logic                   sub_bytes_out_req_i,
  output logic                   sub_bytes_out_ack_o,
  output add_rk_sel_e            add_rk_sel_o,
  output key_full_sel_e          key_full_sel_o,
  output logic                   key_full_we_o,
  output key_dec_sel_e           key_dec_sel_o,
  output logic                   key_dec_we_o,
  output logic                   key_expand_en_o,
  input  logic                   key_expand_out_req_i,
  output logic                   key_expand_out_ack_o,
  output logic                   key_expand_clear_o,
  output key_words_sel_e         key_words_sel_o,
  output round_key_sel_e         round_key_sel_o,
  output logic [RndCtrWidth-1:0] rnd_ctr_o,
  input  logic                   fatal_i,
  output logic                   alert_o
);

  round_if   u_rnd_if ();
  key_sel_if u_sel_if ();

  aes_cipher_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .in_valid_i,
    .in_ready_o,
    .out_valid_o,
    .out_ready_i,
    .op_i,
    .key_len_i,
    .crypt_i,
    .dec_key_gen_i,
    .key_clear_i,
    .data_out_clear_i,
    .state_sel_o,
    .state_we_o,
    .sub_bytes_en_o,
    .sub_bytes_out_req_i,
    .sub_bytes_out_ack_o,
    .add_rk_sel_o,
    .key_full_we_o,
    .key_dec_sel_o,
    .key_dec_we_o,
    .key_expand_en_o,
    .key_expand_out_req_i,
    .key_expand_out_ack_o,
    .key_expand_clear_o,
    .fatal_i,
    .alert_o,
    .rnd                  (u_rnd_if.fsm),
    .sel                  (u_sel_if.fsm)
  );

  aes_round_timer #(
    .SBoxLatency (SBoxLatency)
  ) u_timer (
    .clk_i,
    .rst_ni,
    .rnd    (u_rnd_if.timer)
  );

  aes_key_sel u_key_sel (
    .sel (u_sel_if.dec)
  );

  // Decoded selectors and round count out to the data path
  assign key_full_sel_o  = u_sel_if.key_full_sel;
  assign key_words_sel_o = u_sel_if.key_words_sel;
  assign round_key_sel_o = u_sel_if.round_key_sel;
  assign rnd_ctr_o       = u_rnd_if.rnd_ctr;

endmodule

`default_nettype wire

//--- tests/aes_ctrl_vectors.svh
////////////////////
// Command table for the cipher control testbench
// op and key length are held for the whole command, the DUT reads them live
////////////////////
`ifndef AES_CTRL_VECTORS_SVH
`define AES_CTRL_VECTORS_SVH

// NONE is a handshake without any command bit set
typedef enum logic [2:0] {
  CMD_CRYPT,
  CMD_KEY_GEN,
  CMD_DATA_CLEAR,
  CMD_KEY_CLEAR,
  CMD_NONE,
  CMD_FATAL
} cmd_kind_e;

typedef struct packed {
  cmd_kind_e      kind;
  ciph_op_e       op;
  key_len_e       key_len;
  logic [3:0]     hold;
  logic [3:0]     rounds;
  key_words_sel_e init_words;
  key_words_sel_e later_words;
} vector_t;

localparam int NumVectors = 14;

// Columns: kind, op, key length, cycles with out_ready_i low, round total,
// key words at INIT, key words at each SubBytes hand-over
localparam vector_t Vectors [NumVectors] = '{
  '{CMD_CRYPT,      CIPH_FWD, AES_128, 4'd0, 4'd10, KEY_WORDS_0123, KEY_WORDS_0123},
  '{CMD_CRYPT,      CIPH_INV, AES_128, 4'd2, 4'd10, KEY_WORDS_0123, KEY_WORDS_0123},
  '{CMD_CRYPT,      CIPH_FWD, AES_192, 4'd0, 4'd12, KEY_WORDS_0123, KEY_WORDS_2345},
  '{CMD_CRYPT,      CIPH_INV, AES_192, 4'd1, 4'd12, KEY_WORDS_2345, KEY_WORDS_0123},
  '{CMD_CRYPT,      CIPH_FWD, AES_256, 4'd3, 4'd14, KEY_WORDS_0123, KEY_WORDS_4567},
  '{CMD_CRYPT,      CIPH_INV, AES_256, 4'd0, 4'd14, KEY_WORDS_4567, KEY_WORDS_0123},
  '{CMD_KEY_GEN,    CIPH_FWD, AES_128, 4'd0, 4'd10, KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_KEY_GEN,    CIPH_INV, AES_256, 4'd2, 4'd14, KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_KEY_GEN,    CIPH_FWD, AES_192, 4'd1, 4'd12, KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_DATA_CLEAR, CIPH_FWD, AES_128, 4'd1, 4'd0,  KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_KEY_CLEAR,  CIPH_FWD, AES_128, 4'd0, 4'd0,  KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_NONE,       CIPH_FWD, AES_128, 4'd0, 4'd0,  KEY_WORDS_ZERO, KEY_WORDS_ZERO},
  '{CMD_CRYPT,      CIPH_INV, AES_192, 4'd0, 4'd12, KEY_WORDS_2345, KEY_WORDS_0123},
  '{CMD_FATAL,      CIPH_FWD, AES_128, 4'd0, 4'd0,  KEY_WORDS_ZERO, KEY_WORDS_ZERO}
};

`endif

//--- tests/aes_cipher_control_tb.sv
////////////////////
// Testbench for the AES cipher control unit
// SubBytes and KeyExpand are modeled by random-delay req/ack responders
// Error commands end in a reset, the next row starts from IDLE
////////////////////
`timescale 1ns/1ps
`default_nettype none

module aes_cipher_control_tb import aes_ctrl_pkg::*; ();

  localparam int SBoxLatency = 5;
  localparam int ClkPeriod   = 100;

  `include "aes_ctrl_vectors.svh"

  // Generous per-row budget, the longest crypt needs about 120 cycles
  localparam int WatchdogCycles = 200 * NumVectors + 20;

  logic clk_i;
  logic rst_ni;
  logic in_valid_i;
  logic in_ready_o;
  logic out_valid_o;
  logic out_ready_i;
  ciph_op_e op_i;
  key_len_e key_len_i;
  logic crypt_i;
  logic dec_key_gen_i;
  logic key_clear_i;
  logic data_out_clear_i;
  state_sel_e state_sel_o;
  logic state_we_o;
  logic sub_bytes_en_o;
  logic sub_bytes_out_req_i;
  logic sub_bytes_out_ack_o;
  add_rk_sel_e add_rk_sel_o;
  key_full_sel_e key_full_sel_o;
  logic key_full_we_o;
  key_dec_sel_e key_dec_sel_o;
  logic key_dec_we_o;
  logic key_expand_en_o;
  logic key_expand_out_req_i;
  logic key_expand_out_ack_o;
  logic key_expand_clear_o;
  key_words_sel_e key_words_sel_o;
  round_key_sel_e round_key_sel_o;
  logic [RndCtrWidth-1:0] rnd_ctr_o;
  logic fatal_i;
  logic alert_o;

  // Per-row bookkeeping
  vector_t cur;
  int seed = 32'h27a5_8ce6;
  int errors;
  int cycle;
  int ke_acks;
  int ke_clears;
  int dec_we_cnt;
  int sb_en_cycles;
  int last_ack_cycle;
  bit state_clear_seen;
  bit key_clear_seen;
  bit valid_seen;
  bit hold_pending;
  // Outputs as sampled in the middle of the last cycle
  bit seen_out_valid;
  bit seen_in_ready;
  bit seen_alert;
  bit seen_strobes;
  logic [RndCtrWidth-1:0] seen_rnd_ctr;

  aes_cipher_control #(
    .SBoxLatency (SBoxLatency)
  ) DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // Sample at the falling edge, return 5 ns after the next rising edge
  task automatic sample_cycle();
    logic exp_mixed;
    @(negedge clk_i);
    // Regular rounds are the cycles with KeyExpand on and round add-round-key
    exp_mixed = (op_i == CIPH_INV) && key_expand_en_o && (add_rk_sel_o == ADD_RK_ROUND);
    seen_out_valid = out_valid_o;
    seen_in_ready  = in_ready_o;
    seen_alert     = alert_o;
    seen_rnd_ctr   = rnd_ctr_o;
    seen_strobes   = state_we_o | key_full_we_o | key_dec_we_o | sub_bytes_out_ack_o
                     | key_expand_out_ack_o;
    if (add_rk_sel_o == ADD_RK_INIT && key_words_sel_o != cur.init_words) begin
      report_mismatch("key_words_sel_o", 32'(key_words_sel_o), 32'(cur.init_words));
    end
    if (sub_bytes_out_ack_o && key_words_sel_o != cur.later_words) begin
      report_mismatch("key_words_sel_o", 32'(key_words_sel_o), 32'(cur.later_words));
    end
    if ((round_key_sel_o == ROUND_KEY_MIXED) != exp_mixed) begin
      report_mismatch("round_key_sel_o", 32'(round_key_sel_o), 32'(exp_mixed));
    end
    if (out_valid_o && cur.kind == CMD_CRYPT && rnd_ctr_o != cur.rounds) begin
      report_mismatch("rnd_ctr_o", 32'(rnd_ctr_o), 32'(cur.rounds));
    end
    // Back-pressure holds the result
    if (hold_pending && (!out_valid_o || in_ready_o)) begin
      report_problem("result not held while out_ready_i was low");
    end
    hold_pending = out_valid_o && !out_ready_i;
    if (key_expand_out_ack_o) begin
      ke_acks++;
      if (last_ack_cycle >= 0 && cycle - last_ack_cycle < SBoxLatency) begin
        report_problem($sformatf("KeyExpand acks only %0d cycles apart",
                                 cycle - last_ack_cycle));
      end
      last_ack_cycle = cycle;
    end
    if (key_expand_clear_o) ke_clears++;
    if (key_dec_we_o) dec_we_cnt++;
    // Key generation writes the expanded decryption key
    if (key_dec_we_o && cur.kind == CMD_KEY_GEN && key_dec_sel_o != KEY_DEC_EXPAND) begin
      report_mismatch("key_dec_sel_o", 32'(key_dec_sel_o), 32'(KEY_DEC_EXPAND));
    end
    if (sub_bytes_en_o) sb_en_cycles++;
    if (state_we_o && state_sel_o == STATE_CLEAR && !valid_seen) state_clear_seen = 1'b1;
    if (key_full_sel_o == KEY_FULL_CLEAR && key_full_we_o && key_dec_we_o
        && key_dec_sel_o == KEY_DEC_CLEAR) begin
      key_clear_seen = 1'b1;
    end
    if (out_valid_o) valid_seen = 1'b1;
    if (alert_o && cur.kind != CMD_NONE && cur.kind != CMD_FATAL) begin
      report_problem("alert_o raised without a fault");
    end
    cycle++;
    @(posedge clk_i);
    #5;
  endtask

  // Three cycles of reset, then one idle cycle with all strobes low
  task automatic reset_dut();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    hold_pending = 1'b0;
    sample_cycle();
    if (seen_alert || seen_out_valid || seen_strobes || !seen_in_ready) begin
      report_problem("handshake, strobe or alert outputs wrong after reset");
    end
    if (seen_rnd_ctr != '0) report_mismatch("rnd_ctr_o", 32'(seen_rnd_ctr), 32'h0);
  endtask

  task automatic run_vector(input vector_t v);
    int held;
    bit done;
    int exp_acks;
    int exp_clears;
    cur              = v;
    ke_acks          = 0;
    ke_clears        = 0;
    dec_we_cnt       = 0;
    sb_en_cycles     = 0;
    last_ack_cycle   = -1;
    state_clear_seen = 1'b0;
    key_clear_seen   = 1'b0;
    valid_seen       = 1'b0;
    hold_pending     = 1'b0;
    op_i             = v.op;
    key_len_i        = v.key_len;
    in_valid_i       = (v.kind != CMD_FATAL);
    crypt_i          = (v.kind == CMD_CRYPT);
    dec_key_gen_i    = (v.kind == CMD_KEY_GEN);
    data_out_clear_i = (v.kind == CMD_DATA_CLEAR);
    key_clear_i      = (v.kind == CMD_KEY_CLEAR);
    fatal_i          = (v.kind == CMD_FATAL);
    out_ready_i      = (v.hold == 4'd0);
    sample_cycle();
    if (!seen_in_ready) report_problem("in_ready_o low in the command cycle");
    in_valid_i       = 1'b0;
    crypt_i          = 1'b0;
    dec_key_gen_i    = 1'b0;
    data_out_clear_i = 1'b0;
    key_clear_i      = 1'b0;
    fatal_i          = 1'b0;
    if (v.kind == CMD_NONE || v.kind == CMD_FATAL) begin
      // Alert stays up until reset
      repeat (4) begin
        sample_cycle();
        if (!seen_alert) report_mismatch("alert_o", 32'h0, 32'h1);
      end
      reset_dut();
    end else begin
      held = 0;
      done = 1'b0;
      while (!done) begin
        sample_cycle();
        if (seen_out_valid) begin
          if (out_ready_i) begin
            done = 1'b1;
          end else begin
            held++;
            if (held >= int'(v.hold)) out_ready_i = 1'b1;
          end
        end
      end
      out_ready_i = 1'b0;
      // KeyExpand restarts once for each crypt or key generation, never on a clear
      exp_clears = (v.kind == CMD_CRYPT || v.kind == CMD_KEY_GEN) ? 1 : 0;
      if (ke_clears != exp_clears) begin
        report_mismatch("key_expand_clear_o count", 32'(ke_clears), 32'(exp_clears));
      end
      case (v.kind)
        CMD_CRYPT: begin
          // AES-256 starts with two round keys, one KeyExpand step fewer
          exp_acks = (v.key_len == AES_256) ? int'(v.rounds) - 1 : int'(v.rounds);
          if (ke_acks != exp_acks) begin
            report_mismatch("key_expand_out_ack_o count", 32'(ke_acks), 32'(exp_acks));
          end
        end
        CMD_KEY_GEN: begin
          if (dec_we_cnt != 1) report_mismatch("key_dec_we_o count", 32'(dec_we_cnt), 32'h1);
          if (sb_en_cycles != 0) report_problem("SubBytes enabled during key generation");
        end
        CMD_DATA_CLEAR: begin
          if (!state_clear_seen) report_problem("no state clear write before out_valid_o");
        end
        CMD_KEY_CLEAR: begin
          if (!key_clear_seen) report_problem("no full key clear with decryption key write");
        end
        default: begin
        end
      endcase
      sample_cycle();
      if (!seen_in_ready) report_problem("in_ready_o low after the command completed");
    end
  endtask

  // Both units share one random stream, req drops in the cycle after ack
  initial begin : unit_responder
    logic [1:0] en_s;
    logic [1:0] ack_s;
    logic [1:0] req_v;
    int         wait_cnt [2];
    req_v                = '0;
    wait_cnt[0]          = 0;
    wait_cnt[1]          = 0;
    sub_bytes_out_req_i  = 1'b0;
    key_expand_out_req_i = 1'b0;
    forever begin
      @(negedge clk_i);
      en_s  = {key_expand_en_o, sub_bytes_en_o};
      ack_s = {key_expand_out_ack_o, sub_bytes_out_ack_o};
      @(posedge clk_i);
      #5;
      for (int u = 0; u < 2; u++) begin
        if (!rst_ni || !en_s[u] || ack_s[u]) begin
          req_v[u]    = 1'b0;
          wait_cnt[u] = 0;
        end else if (!req_v[u]) begin
          if (wait_cnt[u] == 0) wait_cnt[u] = 1 + int'($unsigned($random(seed)) % 7);
          wait_cnt[u] = wait_cnt[u] - 1;
          req_v[u]    = (wait_cnt[u] == 0);
        end
      end
      sub_bytes_out_req_i  = req_v[0];
      key_expand_out_req_i = req_v[1];
    end
  end

  initial begin : main_seq
    rst_ni           = 1'b0;
    in_valid_i       = 1'b0;
    out_ready_i      = 1'b0;
    op_i             = CIPH_FWD;
    key_len_i        = AES_128;
    crypt_i          = 1'b0;
    dec_key_gen_i    = 1'b0;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
    fatal_i          = 1'b0;
    cur              = '0;
    errors           = 0;
    cycle            = 0;
    last_ack_cycle   = -1;
    reset_dut();
    for (int i = 0; i < NumVectors; i++) begin
      run_vector(Vectors[i]);
    end
    $display("Vectors applied: %0d, errors: %0d", NumVectors, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: run did not finish within %0d cycles", WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- aes_cipher_control.f
+incdir+tests
design/aes_ctrl_pkg.sv
design/aes_ctrl_if.sv
design/aes_round_timer.sv
design/aes_key_sel.sv
design/aes_cipher_fsm.sv
design/aes_cipher_control.sv
tests/aes_cipher_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cipher control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f aes_cipher_control.f \
  --top-module aes_cipher_control_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
